// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := mmuTb
FILELIST := build.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS     := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run the testbench, fail unless it passes"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: build.f
src/mmuPkg.sv
src/tlbLookupIf.sv
src/tlbArray.sv
src/segmentMapper.sv
src/mmu.sv
verification/tbClock.sv
verification/mmu_sva.sv
verification/mmuTb.sv

// File: src/mmu.sv
`timescale 1ns/1ps
`default_nettype none

module mmu import mmuPkg::*; #(
	parameter int numEntries = 16,
	localparam int idxW = $clog2(numEntries)
) (
	input logic clk,
	input logic rstN,

	// Instruction fetch
	input vaddrT iVaddr,
	output paddrT iPaddr,
	output logic iTlbRefill,
	output logic iTlbInvalid,

	// Data access
	input logic [3:0] dWriteEn,
	input logic dReadEn,
	input vaddrT dVaddr,
	output paddrT dPaddr,
	output logic dTlbRefill,
	output logic dTlbInvalid,
	output logic dTlbModified,

	// CP0 TLB instructions
	input logic tlbwr,
	input logic tlbwi,
	input logic tlbr,
	input logic tlbp,

	// CP0 register values from the core
	input logic [31:0] index,
	input logic [31:0] random,
	input logic [31:0] entryHi,
	input logic [31:0] entryLo0,
	input logic [31:0] entryLo1,

	// TLBR and TLBP results
	output logic indexP,
	output logic [idxW-1:0] indexValue,
	output vpn2T entryHiVpn2,
	output asidT entryHiAsid,
	output pfnT entryLo0Pfn,
	output dvT entryLo0Dv,
	output pfnT entryLo1Pfn,
	output dvT entryLo1Dv,
	output logic entryLoG
);

	tlbOpT op;
	logic dStore;

	tlbLookupIf instPort ();
	tlbLookupIf dataPort ();

	// Strobe priority: TLBWI, TLBWR, TLBR, TLBP
	always_comb begin
		if (tlbwi) begin
			op = opWriteIndexed;
		end else if (tlbwr) begin
			op = opWriteRandom;
		end else if (tlbr) begin
			op = opRead;
		end else if (tlbp) begin
			op = opProbe;
		end else begin
			op = opNone;
		end
	end

	// Any byte lane means a store
	assign dStore = |dWriteEn;

	////////////////////////////////////////////////////////////////////////////
	// TLB and the two segment mappers
	////////////////////////////////////////////////////////////////////////////

	tlbArray #(
		.numEntries(numEntries)
	) tlb (
		.clk(clk),
		.rstN(rstN),
		.op(op),
		.index(index),
		.random(random),
		.entryHi(entryHi),
		.entryLo0(entryLo0),
		.entryLo1(entryLo1),
		.instPort(instPort.tlb),
		.dataPort(dataPort.tlb),
		.indexP(indexP),
		.indexValue(indexValue),
		.entryHiVpn2(entryHiVpn2),
		.entryHiAsid(entryHiAsid),
		.entryLo0Pfn(entryLo0Pfn),
		.entryLo0Dv(entryLo0Dv),
		.entryLo1Pfn(entryLo1Pfn),
		.entryLo1Dv(entryLo1Dv),
		.entryLoG(entryLoG)
	);

	// Fetch side, always active
	segmentMapper #(
		.isDataStream(1'b0)
	) instMapper (
		.vaddr(iVaddr),
		.accessWrite(1'b0),
		.accessRead(1'b1),
		.paddr(iPaddr),
		.refill(iTlbRefill),
		.invalid(iTlbInvalid),
		.modified(),
		.tlb(instPort.mapper)
	);

	segmentMapper #(
		.isDataStream(1'b1)
	) dataMapper (
		.vaddr(dVaddr),
		.accessWrite(dStore),
		.accessRead(dReadEn),
		.paddr(dPaddr),
		.refill(dTlbRefill),
		.invalid(dTlbInvalid),
		.modified(dTlbModified),
		.tlb(dataPort.mapper)
	);

endmodule

`default_nettype wire

// File: src/mmuPkg.sv
`default_nettype none

package mmuPkg;

	////////////////////////////////////////////////////////////////////////////
	// Address and page types
	////////////////////////////////////////////////////////////////////////////

	// Virtual address from fetch or load/store unit
	typedef logic [31:0] vaddrT;
	// Physical address toward the caches
	typedef logic [31:0] paddrT;
	// Page-pair number, vaddr[31:13]
	typedef logic [18:0] vpn2T;
	// Physical frame number, one 4 KB page
	typedef logic [19:0] pfnT;
	// Address space identifier
	typedef logic [7:0] asidT;
	// Dirty in bit 1, valid in bit 0
	typedef logic [1:0] dvT;

	////////////////////////////////////////////////////////////////////////////
	// TLB maintenance operations
	////////////////////////////////////////////////////////////////////////////

	// One operation per cycle, encoded from the CP0 instruction strobes
	typedef enum logic [2:0] {
		opNone,
		opWriteIndexed,
		opWriteRandom,
		opRead,
		opProbe
	} tlbOpT;

	////////////////////////////////////////////////////////////////////////////
	// Segment decode on vaddr[31:29]
	////////////////////////////////////////////////////////////////////////////

	// Kuseg only looks at bit 31
	localparam logic [2:0] segKuseg = 3'b000;
	// Unmapped, cached
	localparam logic [2:0] segKseg0 = 3'b100;
	// Unmapped, uncached
	localparam logic [2:0] segKseg1 = 3'b101;
	// Mapped supervisor segment
	localparam logic [2:0] segKsseg = 3'b110;
	// Mapped kernel segment
	localparam logic [2:0] segKseg3 = 3'b111;

endpackage

`default_nettype wire

// File: src/segmentMapper.sv
`timescale 1ns/1ps
`default_nettype none

module segmentMapper import mmuPkg::*; #(
	parameter bit isDataStream = 1'b0
) (
	input vaddrT vaddr,
	input logic accessWrite,
	input logic accessRead,
	output paddrT paddr,
	output logic refill,
	output logic invalid,
	output logic modified,
	tlbLookupIf.mapper tlb
);

	logic [2:0] seg;
	logic isKuseg;
	logic isKseg0;
	logic isKseg1;
	logic isKsseg;
	logic isKseg3;
	logic unmapped;
	logic mapped;
	logic active;

	////////////////////////////////////////////////////////////////////////////
	// Segment decode
	////////////////////////////////////////////////////////////////////////////

	assign seg = vaddr[31:29];
	// Lower 2 GB, user space
	assign isKuseg = (seg[2] == segKuseg[2]);
	assign isKseg0 = (seg == segKseg0);
	assign isKseg1 = (seg == segKseg1);
	assign isKsseg = (seg == segKsseg);
	assign isKseg3 = (seg == segKseg3);

	assign unmapped = isKseg0 | isKseg1;
	assign mapped = isKuseg | isKsseg | isKseg3;

	// Fetch never stalls; data only while a load or store is issued
	assign active = isDataStream ? (accessRead | accessWrite) : 1'b1;

	// Request toward the TLB
	assign tlb.vaddr = vaddr;
	// Instruction stream never writes
	assign tlb.isWrite = isDataStream ? accessWrite : 1'b0;

	////////////////////////////////////////////////////////////////////////////
	// Result select
	////////////////////////////////////////////////////////////////////////////

	// kseg0/kseg1 drop the top three bits
	assign paddr = unmapped ? {3'b000, vaddr[28:0]} : tlb.paddr;

	assign refill = mapped & active & tlb.refill;
	assign invalid = mapped & active & tlb.invalid;
	// Store gating already done inside the TLB
	assign modified = mapped & active & tlb.modified;

endmodule

`default_nettype wire

// File: src/tlbArray.sv
`timescale 1ns/1ps
`default_nettype none

module tlbArray import mmuPkg::*; #(
	parameter int numEntries = 16,
	localparam int idxW = $clog2(numEntries)
) (
	input logic clk,
	input logic rstN,
	input tlbOpT op,
	input logic [31:0] index,
	input logic [31:0] random,
	input logic [31:0] entryHi,
	input logic [31:0] entryLo0,
	input logic [31:0] entryLo1,
	tlbLookupIf.tlb instPort,
	tlbLookupIf.tlb dataPort,
	output logic indexP,
	output logic [idxW-1:0] indexValue,
	output vpn2T entryHiVpn2,
	output asidT entryHiAsid,
	output pfnT entryLo0Pfn,
	output dvT entryLo0Dv,
	output pfnT entryLo1Pfn,
	output dvT entryLo1Dv,
	output logic entryLoG
);

	// Packed lookup result: paddr, refill, invalid, modified
	typedef logic [$bits(paddrT)+2:0] lookupResT;

	////////////////////////////////////////////////////////////////////////////
	// Entry storage
	////////////////////////////////////////////////////////////////////////////

	vpn2T vpn2Mem [numEntries];
	asidT asidMem [numEntries];
	dvT dv0Mem [numEntries];
	dvT dv1Mem [numEntries];
	pfnT pfn0Mem [numEntries];
	pfnT pfn1Mem [numEntries];
	logic [numEntries-1:0] gMem;
	// Set on first write so a reset entry never matches
	logic [numEntries-1:0] liveMem;

	// Fields taken from the CP0 register words
	vpn2T hiVpn2;
	asidT curAsid;
	pfnT wrPfn0;
	pfnT wrPfn1;
	dvT wrDv0;
	dvT wrDv1;
	logic wrG;

	logic doWrite;
	logic [idxW-1:0] wrIdx;
	logic [idxW-1:0] rdIdx;
	logic [idxW:0] probeRes;

	assign hiVpn2 = entryHi[31:13];
	assign curAsid = entryHi[7:0];
	// EntryLo layout: PFN 25:6, D 2, V 1, G 0
	assign wrPfn0 = entryLo0[25:6];
	assign wrPfn1 = entryLo1[25:6];
	assign wrDv0 = entryLo0[2:1];
	assign wrDv1 = entryLo1[2:1];
	// Global only if both halves say so
	assign wrG = entryLo0[0] & entryLo1[0];

	assign doWrite = (op == opWriteIndexed) || (op == opWriteRandom);
	assign wrIdx = (op == opWriteRandom) ? random[idxW-1:0] : index[idxW-1:0];
	assign rdIdx = index[idxW-1:0];

	// Match and valid state
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numEntries; i++) begin
				vpn2Mem[i] <= '0;
				asidMem[i] <= '0;
				dv0Mem[i] <= '0;
				dv1Mem[i] <= '0;
			end
			gMem <= '0;
			liveMem <= '0;
		end else if (doWrite) begin
			vpn2Mem[wrIdx] <= hiVpn2;
			asidMem[wrIdx] <= curAsid;
			dv0Mem[wrIdx] <= wrDv0;
			dv1Mem[wrIdx] <= wrDv1;
			gMem[wrIdx] <= wrG;
			liveMem[wrIdx] <= 1'b1;
		end
	end

	// Frame numbers
	always_ff @(posedge clk) begin
		if (doWrite) begin
			pfn0Mem[wrIdx] <= wrPfn0;
			pfn1Mem[wrIdx] <= wrPfn1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Match logic shared by both ports and the probe
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [numEntries-1:0] matchLines(input vpn2T vpn2, input asidT asid);
		logic [numEntries-1:0] hits;
		for (int i = 0; i < numEntries; i++) begin
			hits[i] = liveMem[i] && (vpn2Mem[i] == vpn2) && (gMem[i] || (asidMem[i] == asid));
		end
		return hits;
	endfunction

	// Lowest matching index wins, found flag on top
	function automatic logic [idxW:0] firstHit(input logic [numEntries-1:0] hits);
		logic found;
		logic [idxW-1:0] sel;
		found = 1'b0;
		sel = '0;
		for (int i = numEntries - 1; i >= 0; i--) begin
			if (hits[i]) begin
				found = 1'b1;
				sel = idxW'(i);
			end
		end
		return {found, sel};
	endfunction

	function automatic lookupResT translate(input vaddrT va, input logic isWrite);
		logic [idxW:0] hit;
		logic found;
		logic [idxW-1:0] sel;
		pfnT pfn;
		dvT dv;
		hit = firstHit(matchLines(va[31:13], curAsid));
		found = hit[idxW];
		sel = hit[idxW-1:0];
		// Bit 12 picks the odd page
		pfn = va[12] ? pfn1Mem[sel] : pfn0Mem[sel];
		dv = va[12] ? dv1Mem[sel] : dv0Mem[sel];
		return {pfn, va[11:0], !found, found && !dv[0], found && dv[0] && !dv[1] && isWrite};
	endfunction

	always_comb begin
		{instPort.paddr, instPort.refill, instPort.invalid, instPort.modified} =
			translate(instPort.vaddr, instPort.isWrite);
	end

	always_comb begin
		{dataPort.paddr, dataPort.refill, dataPort.invalid, dataPort.modified} =
			translate(dataPort.vaddr, dataPort.isWrite);
	end

	// Probe uses EntryHi VPN2 and ASID
	always_comb begin
		probeRes = firstHit(matchLines(hiVpn2, curAsid));
	end

	////////////////////////////////////////////////////////////////////////////
	// TLBR and TLBP results, held until the next one
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			indexP <= 1'b1;
			indexValue <= '0;
			entryHiVpn2 <= '0;
			entryHiAsid <= '0;
			entryLo0Pfn <= '0;
			entryLo0Dv <= '0;
			entryLo1Pfn <= '0;
			entryLo1Dv <= '0;
			entryLoG <= 1'b0;
		end else begin
			case (op)
				opRead: begin
					entryHiVpn2 <= vpn2Mem[rdIdx];
					entryHiAsid <= asidMem[rdIdx];
					entryLo0Pfn <= pfn0Mem[rdIdx];
					entryLo0Dv <= dv0Mem[rdIdx];
					entryLo1Pfn <= pfn1Mem[rdIdx];
					entryLo1Dv <= dv1Mem[rdIdx];
					entryLoG <= gMem[rdIdx];
				end
				opProbe: begin
					indexP <= !probeRes[idxW];
					// Index keeps its old value on a failed probe
					if (probeRes[idxW]) begin
						indexValue <= probeRes[idxW-1:0];
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/tlbLookupIf.sv
`timescale 1ns/1ps
`default_nettype none

// One translation port between a segment mapper and the TLB array
interface tlbLookupIf import mmuPkg::*; ();

	// Request side
	vaddrT vaddr;
	// High only for stores on the data stream
	logic isWrite;

	// Result side, purely combinational
	paddrT paddr;
	logic refill;
	logic invalid;
	logic modified;

	// Segment mapper end
	modport mapper (
		output vaddr, isWrite,
		input paddr, refill, invalid, modified
	);

	// TLB array end
	modport tlb (
		input vaddr, isWrite,
		output paddr, refill, invalid, modified
	);

endinterface

`default_nettype wire

// File: verification/mmuTb.sv
`timescale 1ns/1ps
`default_nettype none

module mmuTb import mmuPkg::*; ();

	localparam int numEntries = 16;
	localparam int idxW = $clog2(numEntries);
	// Rough cycle budget of all tests plus slack
	localparam int testCycles = 320;
	localparam int marginCycles = 200;

	logic clk, rstN;
	vaddrT iVaddr, dVaddr;
	paddrT iPaddr, dPaddr;
	logic iTlbRefill, iTlbInvalid, dTlbRefill, dTlbInvalid, dTlbModified;
	logic [3:0] dWriteEn;
	logic dReadEn, tlbwr, tlbwi, tlbr, tlbp;
	logic [31:0] index, random, entryHi, entryLo0, entryLo1;
	logic indexP;
	logic [idxW-1:0] indexValue;
	vpn2T entryHiVpn2;
	asidT entryHiAsid;
	pfnT entryLo0Pfn, entryLo1Pfn;
	dvT entryLo0Dv, entryLo1Dv;
	logic entryLoG;

	// Shadow copy of the TLB
	logic shLive [numEntries];
	vpn2T shVpn2 [numEntries];
	asidT shAsid [numEntries];
	logic shG [numEntries];
	pfnT shPfn0 [numEntries];
	pfnT shPfn1 [numEntries];
	dvT shDv0 [numEntries];
	dvT shDv1 [numEntries];

	int seed = 32'hedc1;
	int checks = 0;
	int errors = 0;
	int testNum = 0;
	int testErrBase = 0;
	logic checkEn = 1'b0;
	logic [35:0] expI, expD;

	tbClock #(.periodNs(8), .resetCycles(3)) clkGen (.clk(clk), .rstN(rstN));

	mmu #(.numEntries(numEntries)) DUT (.*);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Lowest matching index or -1 on a miss
	function automatic int findEntry(input vpn2T vpn2, input asidT asid);
		for (int i = 0; i < numEntries; i++) begin
			if (shLive[i] && shVpn2[i] == vpn2 && (shG[i] || shAsid[i] == asid))
				return i;
		end
		return -1;
	endfunction

	// Result is {paddr valid, paddr, refill, invalid, modified}
	function automatic logic [35:0] refTranslate(input vaddrT va, input logic isWrite,
			input logic active, input asidT asid);
		int hit;
		dvT dv;
		pfnT pfn;
		if (va[31:30] == 2'b10)
			return {1'b1, 3'b000, va[28:0], 3'b000};
		hit = findEntry(va[31:13], asid);
		if (hit < 0)
			return {1'b0, 32'h0, active, 2'b00};
		dv = va[12] ? shDv1[hit] : shDv0[hit];
		pfn = va[12] ? shPfn1[hit] : shPfn0[hit];
		return {1'b1, pfn, va[11:0], 1'b0, active && !dv[0],
			active && dv[0] && !dv[1] && isWrite};
	endfunction

	function automatic vpn2T mappedVpn2(input logic [31:0] r);
		// Kuseg, ksseg or kseg3
		return r[31] ? {2'b11, r[16:0]} : {1'b0, r[17:0]};
	endfunction

	task automatic reportError(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	// Compares the lookup outputs in the middle of each lookup cycle
	always @(negedge clk) begin
		if (rstN && checkEn) begin
			expI = refTranslate(iVaddr, 1'b0, 1'b1, entryHi[7:0]);
			expD = refTranslate(dVaddr, |dWriteEn, dReadEn || |dWriteEn, entryHi[7:0]);
			checks++;
			if ({iTlbRefill, iTlbInvalid} !== expI[2:1])
				reportError($sformatf("fetch %h flags %b, expected %b", iVaddr,
					{iTlbRefill, iTlbInvalid}, expI[2:1]));
			if (expI[35] && iPaddr !== expI[34:3])
				reportError($sformatf("fetch %h paddr %h, expected %h", iVaddr, iPaddr,
					expI[34:3]));
			if ({dTlbRefill, dTlbInvalid, dTlbModified} !== expD[2:0])
				reportError($sformatf("data %h flags %b, expected %b", dVaddr,
					{dTlbRefill, dTlbInvalid, dTlbModified}, expD[2:0]));
			if (expD[35] && dPaddr !== expD[34:3])
				reportError($sformatf("data %h paddr %h, expected %h", dVaddr, dPaddr,
					expD[34:3]));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	// One lookup cycle on both streams with mode 0 idle, 1 load or 2 store
	task automatic lookup(input vaddrT iva, input vaddrT dva, input int mode);
		@(posedge clk);
		iVaddr <= iva;
		dVaddr <= dva;
		dReadEn <= (mode == 1);
		dWriteEn <= (mode == 2) ? 4'b0001 << (iva[1:0]) : 4'b0000;
		checkEn <= 1'b1;
	endtask

	task automatic writeEntry(input int idx, input logic useRandom, input vpn2T vpn2,
			input asidT asid, input logic g, input pfnT pfn0, input dvT dv0,
			input pfnT pfn1, input dvT dv1);
		@(posedge clk);
		checkEn <= 1'b0;
		entryHi <= {vpn2, 5'b0, asid};
		entryLo0 <= {6'b0, pfn0, 3'b0, dv0, g};
		entryLo1 <= {6'b0, pfn1, 3'b0, dv1, g};
		if (useRandom) begin
			random <= idx;
			tlbwr <= 1'b1;
		end else begin
			index <= idx;
			tlbwi <= 1'b1;
		end
		@(posedge clk);
		tlbwi <= 1'b0;
		tlbwr <= 1'b0;
		// DUT took the write at this edge
		shLive[idx] = 1'b1;
		shVpn2[idx] = vpn2;
		shAsid[idx] = asid;
		shG[idx] = g;
		shPfn0[idx] = pfn0;
		shPfn1[idx] = pfn1;
		shDv0[idx] = dv0;
		shDv1[idx] = dv1;
	endtask

	task automatic setAsid(input asidT asid);
		@(posedge clk);
		checkEn <= 1'b0;
		entryHi <= {entryHi[31:8], asid};
	endtask

	task automatic readCheck(input int idx);
		@(posedge clk);
		checkEn <= 1'b0;
		index <= idx;
		tlbr <= 1'b1;
		@(posedge clk);
		tlbr <= 1'b0;
		@(negedge clk);
		checks++;
		if (entryHiVpn2 !== shVpn2[idx] || entryHiAsid !== shAsid[idx]
				|| entryLo0Pfn !== shPfn0[idx] || entryLo1Pfn !== shPfn1[idx]
				|| entryLo0Dv !== shDv0[idx] || entryLo1Dv !== shDv1[idx]
				|| entryLoG !== shG[idx])
			reportError($sformatf("TLBR of entry %0d returned wrong fields", idx));
	endtask

	task automatic probeCheck(input vpn2T vpn2, input asidT asid);
		int hit;
		hit = findEntry(vpn2, asid);
		@(posedge clk);
		checkEn <= 1'b0;
		entryHi <= {vpn2, 5'b0, asid};
		tlbp <= 1'b1;
		@(posedge clk);
		tlbp <= 1'b0;
		@(negedge clk);
		checks++;
		if (indexP !== (hit < 0))
			reportError($sformatf("probe of %h gave indexP %b", vpn2, indexP));
		else if (hit >= 0 && int'(indexValue) != hit)
			reportError($sformatf("probe of %h index %0d, expected %0d", vpn2,
				indexValue, hit));
	endtask

	task automatic endTest(input string name);
		testNum++;
		$display("Test %0d %s: %0d errors", testNum, name, errors - testErrBase);
		testErrBase = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r, r2;
		int idx, idx2;
		vpn2T vA, vB;
		iVaddr = '0;
		dVaddr = '0;
		dWriteEn = '0;
		dReadEn = 1'b0;
		{tlbwr, tlbwi, tlbr, tlbp} = 4'b0;
		{index, random, entryHi, entryLo0, entryLo1} = '0;
		for (int i = 0; i < numEntries; i++)
			shLive[i] = 1'b0;
		@(posedge rstN);

		// Nothing written yet so every mapped access misses
		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			lookup({mappedVpn2(r), r2[12:0]}, {mappedVpn2(r2), r[12:0]}, i % 3);
		end
		endTest("empty TLB");

		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			writeEntry(i, 1'b0, mappedVpn2(r), 8'h11, r2[0], r2[19:0], {r[3], 1'b1},
				r[31:12], {r2[5], 1'b1});
		end
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			lookup({shVpn2[r[2:0]], r2[12:0]}, {shVpn2[r2[2:0]], r[12:0]}, r[9:8] % 3);
		end
		endTest("indexed write and translation");

		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			lookup({2'b10, r[29:0]}, {2'b10, r2[29:0]}, i % 3);
		end
		endTest("unmapped bypass");

		r = $random(seed);
		vA = mappedVpn2(r);
		// Even page invalid and odd page clean
		writeEntry(9, 1'b0, vA, 8'h11, 1'b0, r[19:0], 2'b00, r[31:12], 2'b01);
		lookup({vA, 1'b0, 12'h123}, {vA, 1'b0, 12'h456}, 1);
		lookup({vA, 1'b0, 12'h124}, {vA, 1'b0, 12'h458}, 2);
		lookup({vA, 1'b1, 12'h128}, {vA, 1'b1, 12'h45c}, 1);
		lookup({vA, 1'b1, 12'h12c}, {vA, 1'b1, 12'h460}, 2);
		lookup({vA, 1'b1, 12'h130}, {vA, 1'b1, 12'h464}, 0);
		endTest("invalid and modified");

		r = $random(seed);
		r2 = $random(seed);
		idx = 8 + r[2:0];
		idx2 = idx ^ 1;
		vA = {1'b0, r[31:14]};
		vB = {2'b11, r2[31:15]};
		writeEntry(idx, 1'b1, vA, 8'h42, 1'b0, r2[19:0], 2'b11, r2[31:12], 2'b11);
		writeEntry(idx2, 1'b1, vB, 8'h42, 1'b1, r[19:0], 2'b11, r[31:12], 2'b11);
		lookup({vA, 13'h0a4}, {vB, 13'h1f0}, 1);
		lookup({vB, 13'h0a8}, {vA, 13'h1f4}, 2);
		setAsid(8'h77);
		lookup({vA, 13'h0ac}, {vB, 13'h1f8}, 1);
		lookup({vB, 13'h0b0}, {vA, 13'h1fc}, 1);
		readCheck(idx);
		readCheck(idx2);
		endTest("ASID, global and random write");

		for (int i = 0; i < 8; i++) begin
			probeCheck(shVpn2[i], 8'h11);
			r = $random(seed);
			probeCheck(mappedVpn2(r), 8'h11);
		end
		probeCheck(vA, 8'h42);
		probeCheck(vA, 8'h43);
		endTest("probe");

		$display("Ran %0d tests, %0d checks, %0d errors", testNum, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog
	initial begin
		#((testCycles + marginCycles) * 8);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/mmu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_sva #(
	parameter int numEntries = 16,
	localparam int idxW = $clog2(numEntries)
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [31:0] iVaddr,
	input wire logic [31:0] dVaddr,
	input wire logic iTlbRefill,
	input wire logic iTlbInvalid,
	input wire logic iModified,
	input wire logic dTlbRefill,
	input wire logic dTlbInvalid,
	input wire logic dTlbModified,
	input wire logic indexP,
	input wire logic [idxW-1:0] indexValue
);

	// Miss and invalid page are exclusive
	assert property (@(posedge clk) disable iff (!rstN) !(iTlbRefill && iTlbInvalid))
		else $error("instruction refill and invalid both high");
	assert property (@(posedge clk) disable iff (!rstN) !(dTlbRefill && dTlbInvalid))
		else $error("data refill and invalid both high");

	// Fetches never store
	assert property (@(posedge clk) disable iff (!rstN) !iModified)
		else $error("modified raised on instruction stream");

	// kseg0 and kseg1 bypass the TLB
	assert property (@(posedge clk) disable iff (!rstN)
		(iVaddr[31:30] == 2'b10) |-> !(iTlbRefill || iTlbInvalid))
		else $error("flag on unmapped fetch");
	assert property (@(posedge clk) disable iff (!rstN)
		(dVaddr[31:30] == 2'b10) |-> !(dTlbRefill || dTlbInvalid || dTlbModified))
		else $error("flag on unmapped data access");

	// Successful probe gives an index in range
	assert property (@(posedge clk) disable iff (!rstN)
		!indexP |-> (int'(indexValue) < numEntries))
		else $error("probe index out of range");

endmodule

bind mmu mmu_sva #(.numEntries(numEntries)) sva (
	.clk(clk),
	.rstN(rstN),
	.iVaddr(iVaddr),
	.dVaddr(dVaddr),
	.iTlbRefill(iTlbRefill),
	.iTlbInvalid(iTlbInvalid),
	.iModified(instMapper.modified),
	.dTlbRefill(dTlbRefill),
	.dTlbInvalid(dTlbInvalid),
	.dTlbModified(dTlbModified),
	.indexP(indexP),
	.indexValue(indexValue)
);

`default_nettype wire

// File: verification/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int periodNs = 8,
	parameter int resetCycles = 3
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2.0) clk = ~clk;
	end

	// Reset released on a rising edge
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire
